// ==== build.f ====
hdl/isa_pkg.sv
hdl/retire_pkg.sv
hdl/retire_buffer.sv
hdl/retire_ctrl.sv
hdl/retire_counters.sv
hdl/arch_regfile.sv
hdl/retire_top.sv
verification/retire_checker.sv
verification/retire_tb.sv

// ==== hdl/arch_regfile.sv ====
`timescale 1ns/1ps

module arch_regfile #(
	parameter int READ_PORTS = retire_pkg::DEFAULT_READ_PORTS
) (
	input logic clk,
	input logic rst,
	input logic we,
	input isa_pkg::areg_addr_t wa,
	input isa_pkg::u64 wd,
	input isa_pkg::areg_addr_t [READ_PORTS-1:0] src1,
	input isa_pkg::areg_addr_t [READ_PORTS-1:0] src2,
	output isa_pkg::u64 [READ_PORTS-1:0] rs1_data,
	output isa_pkg::u64 [READ_PORTS-1:0] rs2_data
);
	import isa_pkg::*;

	// storage for x1..x31 only
	u64 regs [1:AREG_NUM-1];
	u64 regs_nxt [1:AREG_NUM-1];
	// read view with x0 pinned to zero
	u64 rd_view [AREG_NUM];

	// next value per register from the retire write
	for (genvar i = 1; i < AREG_NUM; i++) begin : g_nxt
		always_comb begin
			regs_nxt[i] = regs[i];
			if (we && (wa == areg_addr_t'(i))) begin
				regs_nxt[i] = wd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < AREG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			regs <= regs_nxt;
		end
	end

	always_comb begin
		rd_view[0] = '0;
		for (int i = 1; i < AREG_NUM; i++) begin
			rd_view[i] = regs[i];
		end
	end

	// combinational source reads
	for (genvar p = 0; p < READ_PORTS; p++) begin : g_rd
		assign rs1_data[p] = rd_view[src1[p]];
		assign rs2_data[p] = rd_view[src2[p]];
	end

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	// machine word width for rv64
	localparam int XLEN = 64;

	// architectural integer registers, x0 included
	localparam int AREG_NUM = 32;

	// bits needed to name one architectural register
	localparam int AREG_ADDR_W = $clog2(AREG_NUM);

	// one data word, used for results, pc and counters
	typedef logic [XLEN-1:0] u64;

	// architectural register index
	// x0 is the hard-wired zero register
	typedef logic [AREG_ADDR_W-1:0] areg_addr_t;

endpackage

// ==== hdl/retire_buffer.sv ====
`timescale 1ns/1ps

module retire_buffer #(
	parameter int DEPTH = retire_pkg::DEFAULT_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input retire_pkg::retire_entry_t in_entry,
	input logic accept_en,
	input logic flush,
	input logic commit_ready,
	output logic in_ready,
	output logic commit_valid,
	output retire_pkg::retire_entry_t commit_entry,
	output logic retire_fire,
	output logic head_exception
);
	import retire_pkg::*;

	// depth is a power of two so pointers wrap on their own
	localparam int PTR_W = $clog2(DEPTH);
	// count needs one extra value for the full case
	localparam int CNT_W = $clog2(DEPTH + 1);

	retire_entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// input closes when full or while the front end redirects
	assign in_ready = !full && accept_en;
	// head hidden during the flush cycle so nothing younger retires
	assign commit_valid = !empty && !flush;

	assign push = in_valid && in_ready;
	assign pop = commit_valid && commit_ready;

	// head of the queue is always on the commit stream
	assign commit_entry = mem[rd_ptr];
	assign retire_fire = pop;
	assign head_exception = commit_entry.ctl.exception;

	// entry storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_entry;
		end
	end

	// pointers and occupancy
	// flush drops every entry still queued
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hdl/retire_counters.sv ====
`timescale 1ns/1ps

module retire_counters #(
	parameter int FLUSH_CYCLES = retire_pkg::DEFAULT_FLUSH_CYCLES
) (
	input logic clk,
	input logic rst,
	input logic retire_fire,
	input logic head_exception,
	input logic timer_start,
	output isa_pkg::u64 instret,
	output logic timer_done
);
	// wide enough to hold FLUSH_CYCLES itself
	localparam int TMR_W = (FLUSH_CYCLES > 0) ? $clog2(FLUSH_CYCLES + 1) : 1;

	logic [TMR_W-1:0] tmr;
	logic tmr_busy;

	// retired instruction count
	// trapping instructions do not count
	always_ff @(posedge clk) begin
		if (rst) begin
			instret <= '0;
		end else if (retire_fire && !head_exception) begin
			instret <= instret + 1'b1;
		end
	end

	// flush wait down-counter
	always_ff @(posedge clk) begin
		if (rst) begin
			tmr <= '0;
			tmr_busy <= 1'b0;
		end else if (timer_start) begin
			tmr <= TMR_W'(FLUSH_CYCLES);
			tmr_busy <= 1'b1;
		end else if (tmr_busy) begin
			// stop once zero has been reported
			if (tmr == '0) begin
				tmr_busy <= 1'b0;
			end else begin
				tmr <= tmr - 1'b1;
			end
		end
	end

	// one cycle pulse on reaching zero
	assign timer_done = tmr_busy && (tmr == '0);

endmodule

// ==== hdl/retire_ctrl.sv ====
`timescale 1ns/1ps

module retire_ctrl (
	input logic clk,
	input logic rst,
	input logic retire_fire,
	input logic head_exception,
	input logic timer_done,
	output logic flush,
	output logic accept_en,
	output logic timer_start
);
	import retire_pkg::*;

	retire_state_t state;
	retire_state_t state_nxt;

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			RUN: begin
				// trapping instruction just left the buffer
				if (retire_fire && head_exception) begin
					state_nxt = FLUSH;
				end
			end
			FLUSH: begin
				// single cycle, clear happens at its end
				state_nxt = WAIT;
			end
			WAIT: begin
				// front end redirect window over
				if (timer_done) begin
					state_nxt = RUN;
				end
			end
			default: begin
				state_nxt = RUN;
			end
		endcase
	end

	// state and registered outputs
	// outputs follow state_nxt so they line up with the state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RUN;
			flush <= 1'b0;
			accept_en <= 1'b1;
		end else begin
			state <= state_nxt;
			flush <= (state_nxt == FLUSH);
			// closes right after the exception retires
			accept_en <= (state_nxt == RUN);
		end
	end

	// timer launches in the same cycle as the flush pulse
	assign timer_start = flush;

endmodule

// ==== hdl/retire_pkg.sv ====
package retire_pkg;

	// retire buffer entries, must be a power of two
	localparam int DEFAULT_DEPTH = 8;

	// source read port pairs on the register file
	localparam int DEFAULT_READ_PORTS = 2;

	// cycles the input stays closed after a flush
	localparam int DEFAULT_FLUSH_CYCLES = 4;

	// per-instruction control flags carried to retire
	typedef struct packed {
		// result goes to the register file
		logic regwrite;
		// instruction traps, nothing is written or counted
		logic exception;
	} retire_ctl_t;

	// one completed instruction waiting to retire
	typedef struct packed {
		isa_pkg::u64 pc;
		isa_pkg::areg_addr_t dst;
		isa_pkg::u64 data;
		retire_ctl_t ctl;
	} retire_entry_t;

	// retire sequencing states
	// FLUSH is a single cycle, WAIT covers the redirect
	typedef enum logic [1:0] {
		RUN = 2'd0,
		FLUSH = 2'd1,
		WAIT = 2'd2
	} retire_state_t;

endpackage

// ==== hdl/retire_top.sv ====
`timescale 1ns/1ps

module retire_top #(
	parameter int DEPTH = retire_pkg::DEFAULT_DEPTH,
	parameter int READ_PORTS = retire_pkg::DEFAULT_READ_PORTS,
	parameter int FLUSH_CYCLES = retire_pkg::DEFAULT_FLUSH_CYCLES
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input retire_pkg::retire_entry_t in_entry,
	output logic in_ready,
	output logic commit_valid,
	output retire_pkg::retire_entry_t commit_entry,
	input logic commit_ready,
	input isa_pkg::areg_addr_t [READ_PORTS-1:0] src1,
	input isa_pkg::areg_addr_t [READ_PORTS-1:0] src2,
	output isa_pkg::u64 [READ_PORTS-1:0] rs1_data,
	output isa_pkg::u64 [READ_PORTS-1:0] rs2_data,
	output isa_pkg::u64 instret
);
	logic retire_fire;
	logic head_exception;
	logic flush;
	logic accept_en;
	logic timer_start;
	logic timer_done;
	logic rf_we;

	// in-order queue of completed instructions
	retire_buffer #(
		.DEPTH(DEPTH)
	) u_buffer (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_entry(in_entry),
		.accept_en(accept_en),
		.flush(flush),
		.commit_ready(commit_ready),
		.in_ready(in_ready),
		.commit_valid(commit_valid),
		.commit_entry(commit_entry),
		.retire_fire(retire_fire),
		.head_exception(head_exception)
	);

	// run, flush and redirect wait sequencing
	retire_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.retire_fire(retire_fire),
		.head_exception(head_exception),
		.timer_done(timer_done),
		.flush(flush),
		.accept_en(accept_en),
		.timer_start(timer_start)
	);

	retire_counters #(
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) u_counters (
		.clk(clk),
		.rst(rst),
		.retire_fire(retire_fire),
		.head_exception(head_exception),
		.timer_start(timer_start),
		.instret(instret),
		.timer_done(timer_done)
	);

	// trapping instructions never reach the register file
	assign rf_we = retire_fire && commit_entry.ctl.regwrite && !commit_entry.ctl.exception;

	arch_regfile #(
		.READ_PORTS(READ_PORTS)
	) u_regfile (
		.clk(clk),
		.rst(rst),
		.we(rf_we),
		.wa(commit_entry.dst),
		.wd(commit_entry.data),
		.src1(src1),
		.src2(src2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the retire testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module retire_tb -f build.f -o Vretire_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vretire_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# result comes from the log
if grep -qx "TEST PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verification/retire_checker.sv ====
`timescale 1ns/1ps

module retire_checker (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_ready,
	input retire_pkg::retire_entry_t in_entry,
	input logic flush,
	input logic accept_en,
	input logic timer_done
);
	// sticky flags, one per rule
	logic hold_bad = 1'b0;
	logic pulse_bad = 1'b0;
	logic closed_bad = 1'b0;
	logic reopen_bad = 1'b0;
	logic any_fail;

	assign any_fail = hold_bad || pulse_bad || closed_bad || reopen_bad;

	// stalled source keeps its entry
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(in_valid && !in_ready) |=> (in_valid && $stable(in_entry)))
	else begin
		$error("in_entry changed while in_ready was low");
		hold_bad = 1'b1;
	end

	// flush is a single cycle pulse
	a_pulse: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
	else begin
		$error("flush held longer than one cycle");
		pulse_bad = 1'b1;
	end

	// input stays closed from the flush until the timer ends
	a_closed: assert property (@(posedge clk) disable iff (rst)
		(flush || (!accept_en && !timer_done)) |=> !accept_en)
	else begin
		$error("accept_en rose before timer_done");
		closed_bad = 1'b1;
	end

	// redirect over, input opens again
	a_reopen: assert property (@(posedge clk) disable iff (rst) timer_done |=> accept_en)
	else begin
		$error("accept_en still low after timer_done");
		reopen_bad = 1'b1;
	end

endmodule

// ==== verification/retire_stim.txt ====
# push pc dst data regwrite exception | hold idle_cycles | release
# read port reg expected | count expected_instret   (all values hex)
push 1000 01 1111 1 0
push 1004 02 2222 1 0
read 0 01 1111
read 1 02 2222
push 1008 01 aaaa 1 0
read 0 01 aaaa
read 1 01 aaaa
push 100c 00 dead 1 0
read 0 00 0
count 4
push 1010 03 5555 0 0
read 1 03 0
count 5
hold 3
push 1100 04 40 1 0
push 1104 05 45 1 0
push 1108 06 46 1 0
push 110c 07 47 1 0
push 1110 08 48 1 0
push 1114 09 49 1 0
push 1118 0a 4a 1 0
push 111c 0b 4b 1 0
push 1120 04 94 1 0
push 1124 0c 9c 1 0
release
read 0 04 94
read 1 05 45
read 0 0b 4b
read 1 0c 9c
count f
hold 2
push 2000 0e e1 1 0
push 2004 0f f1 1 1
push 2008 10 99 1 0
push 200c 0e 77 1 0
release
read 0 0e e1
read 1 0f 0
read 0 10 0
count 10
push 3000 10 abcd 1 0
read 1 10 abcd
count 11

// ==== verification/retire_tb.sv ====
`timescale 1ns/1ps

module retire_tb;
	import isa_pkg::*;
	import retire_pkg::*;

	localparam int DEPTH = DEFAULT_DEPTH;
	localparam int READ_PORTS = DEFAULT_READ_PORTS;
	localparam int FLUSH_CYCLES = DEFAULT_FLUSH_CYCLES;
	localparam string STIM_FILE = "verification/retire_stim.txt";

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	retire_entry_t in_entry;
	logic in_ready;
	logic commit_valid;
	retire_entry_t commit_entry;
	logic commit_ready;
	areg_addr_t [READ_PORTS-1:0] src1;
	areg_addr_t [READ_PORTS-1:0] src2;
	u64 [READ_PORTS-1:0] rs1_data;
	u64 [READ_PORTS-1:0] rs2_data;
	u64 instret;

	// reference model of the architectural state
	u64 model_rf [AREG_NUM];
	u64 model_cnt;
	retire_entry_t mq [$];
	// pushes that found the buffer full while commit was held
	retire_entry_t pend [$];
	bit held;
	int n_pass = 0;
	int n_fail = 0;
	int n_lines = 0;

	always #5 clk = ~clk;

	retire_top #(
		.DEPTH(DEPTH),
		.READ_PORTS(READ_PORTS),
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) uut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_entry(in_entry),
		.in_ready(in_ready),
		.commit_valid(commit_valid),
		.commit_entry(commit_entry),
		.commit_ready(commit_ready),
		.src1(src1),
		.src2(src2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.instret(instret)
	);

	bind retire_top retire_checker u_checker (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_entry(in_entry),
		.flush(flush),
		.accept_en(accept_en),
		.timer_done(timer_done)
	);

	task automatic check_value(input string name, input u64 exp, input u64 act);
		if (exp === act) begin
			n_pass++;
			$display("ok     %s", name);
		end else begin
			n_fail++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// a stimulus line with missing fields counts as a failure
	task automatic check_fields(input int got, input int want, input string name);
		if (got != want) begin
			n_fail++;
			$display("%s has %0d fields where %0d are needed", name, got, want);
		end
	endtask

	// retire everything queued in the model, in order
	function automatic void drain_model();
		retire_entry_t e;
		while (mq.size() > 0) begin
			e = mq.pop_front();
			if (e.ctl.exception) begin
				// trap writes nothing, younger entries are dropped
				mq.delete();
			end else begin
				if (e.ctl.regwrite && e.dst != '0) begin
					model_rf[e.dst] = e.data;
				end
				model_cnt++;
			end
		end
	endfunction

	// wait for the buffer to empty while commit is open
	task automatic settle();
		while (commit_valid && commit_ready) begin
			@(negedge clk);
		end
	endtask

	task automatic push_entry(input retire_entry_t e, input string name);
		int gap;
		if (held && mq.size() == DEPTH) begin
			check_value({name, " in_ready low when full"}, 64'(0), 64'(in_ready));
			pend.push_back(e);
		end else begin
			in_valid = 1'b1;
			in_entry = e;
			while (!in_ready) begin
				@(negedge clk);
			end
			// handshake on the coming rising edge
			@(negedge clk);
			in_valid = 1'b0;
			mq.push_back(e);
			if (!held) begin
				drain_model();
			end
			gap = int'($urandom % 3);
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic release_commit(input string name);
		bit exp_exc;
		bit saw_exc;
		int lows;
		int k;
		int n_ret;
		retire_entry_t e;
		exp_exc = 1'b0;
		// entries up to and including the first trap leave the buffer
		n_ret = mq.size();
		foreach (mq[i]) begin
			if (mq[i].ctl.exception && !exp_exc) begin
				exp_exc = 1'b1;
				n_ret = i + 1;
			end
		end
		check_value({name, " commit_valid while held"}, 64'(mq.size() != 0), 64'(commit_valid));
		commit_ready = 1'b1;
		saw_exc = 1'b0;
		k = 0;
		while (commit_valid) begin
			// head follows the model queue in program order
			if (k < mq.size()) begin
				check_value({name, " commit pc"}, mq[k].pc, commit_entry.pc);
				check_value({name, " commit dst"}, 64'(mq[k].dst), 64'(commit_entry.dst));
				check_value({name, " commit data"}, mq[k].data, commit_entry.data);
			end else begin
				n_fail++;
				$display("%s retired more entries than were pushed", name);
			end
			if (commit_entry.ctl.exception) begin
				saw_exc = 1'b1;
			end
			k++;
			@(negedge clk);
		end
		check_value({name, " entries retired"}, 64'(n_ret), 64'(k));
		check_value({name, " exception at head"}, 64'(exp_exc), 64'(saw_exc));
		if (saw_exc) begin
			// negedges with the input closed after the trap retired
			lows = 0;
			while (!in_ready && lows <= FLUSH_CYCLES + 2) begin
				lows++;
				@(negedge clk);
			end
			check_value({name, " in_ready reopens in time"}, 64'(1),
				64'(lows >= 1 && lows <= FLUSH_CYCLES + 2));
		end
		held = 1'b0;
		drain_model();
		check_value({name, " instret"}, model_cnt, instret);
		while (pend.size() > 0) begin
			e = pend.pop_front();
			push_entry(e, {name, " deferred push"});
		end
	endtask

	task automatic read_reg(input int port, input areg_addr_t addr, input u64 exp,
		input string name);
		src1[port] = addr;
		src2[port] = addr;
		@(negedge clk);
		check_value({name, " rs1"}, exp, rs1_data[port]);
		check_value({name, " rs2"}, exp, rs2_data[port]);
		check_value({name, " model"}, exp, model_rf[addr]);
	endtask

	task automatic run_file(input int fd);
		string op;
		string rest;
		string name;
		retire_entry_t e;
		u64 a;
		u64 b;
		u64 c;
		u64 d;
		u64 x;
		int code;
		int op_no;
		op_no = 0;
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op.substr(0, 0) == "#") begin
				void'($fgets(rest, fd));
			end else begin
				op_no++;
				name = $sformatf("op %0d %s", op_no, op);
				if (op == "push") begin
					code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, x);
					check_fields(code, 5, name);
					e.pc = a;
					e.dst = areg_addr_t'(b);
					e.data = c;
					e.ctl.regwrite = d[0];
					e.ctl.exception = x[0];
					push_entry(e, name);
				end else if (op == "hold") begin
					code = $fscanf(fd, "%h", a);
					check_fields(code, 1, name);
					settle();
					commit_ready = 1'b0;
					held = 1'b1;
					repeat (int'(a)) @(negedge clk);
				end else if (op == "release") begin
					release_commit(name);
				end else if (op == "read") begin
					code = $fscanf(fd, "%h %h %h", a, b, c);
					check_fields(code, 3, name);
					settle();
					read_reg(int'(a), areg_addr_t'(b), c, name);
				end else if (op == "count") begin
					code = $fscanf(fd, "%h", a);
					check_fields(code, 1, name);
					settle();
					check_value({name, " instret"}, a, instret);
					check_value({name, " model"}, a, model_cnt);
				end else begin
					n_fail++;
					$display("unknown operation %s in stimulus file", op);
				end
			end
		end
	endtask

	// watchdog sized from the stimulus length
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 40) @(posedge clk);
		$display("run timed out after %0d cycles", n_lines * 40);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int fd;
		string line;
		void'($urandom(20377));
		rst = 1'b1;
		in_valid = 1'b0;
		in_entry = '0;
		commit_ready = 1'b1;
		src1 = '0;
		src2 = '0;
		held = 1'b0;
		model_cnt = '0;
		foreach (model_rf[i]) begin
			model_rf[i] = '0;
		end
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			$display("TEST FAIL");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0) begin
				n_lines++;
			end
			$fclose(fd);
			fd = $fopen(STIM_FILE, "r");
			repeat (10) @(negedge clk);
			rst = 1'b0;
			run_file(fd);
			$fclose(fd);
			settle();
			check_value("final instret", model_cnt, instret);
			if (uut.u_checker.any_fail) begin
				$display("checker assertions failed during the run");
			end
			$display("checks passed %0d failed %0d", n_pass, n_fail);
			if (n_fail == 0 && !uut.u_checker.any_fail) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule
